/* filelist.f */
+incdir+include
hdl/ctrl_pkg.sv
hdl/ctrl_exc_encode.sv
hdl/ctrl_fsm.sv
hdl/ctrl_top.sv
tb/tb_ctrl.sv

/* hdl/ctrl_exc_encode.sv */
// load/store error inputs are single-cycle pulses and never high together; mtval only valid in flush
`timescale 1ns/1ps

module ctrl_exc_encode (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // decoder side
  input  ctrl_pkg::dec_flags_t         dec_flags_i,
  input  logic [ctrl_pkg::xlen-1:0]    instr_i,
  input  logic [15:0]                  instr_compressed_i,
  input  logic                         instr_is_compressed_i,

  // lsu side
  input  logic [ctrl_pkg::xlen-1:0]    lsu_addr_last_i,
  input  logic                         load_err_i,
  input  logic                         store_err_i,

  // to the controller fsm
  output logic                         special_req_o,
  output logic                         exc_pending_o,
  output ctrl_pkg::exc_cause_e         exc_cause_o,
  output logic [ctrl_pkg::xlen-1:0]    mtval_o
);
  import ctrl_pkg::*;

  logic load_err_q;
  logic store_err_q;
  logic exc_req_insn;
  logic exc_req_lsu;

  //////////////////////////////
  // request detection
  //////////////////////////////

  // exceptions raised by the instruction itself
  assign exc_req_insn = dec_flags_i.illegal | dec_flags_i.ecall | dec_flags_i.ebreak;

  // raw lsu errors, seen in decode only
  assign exc_req_lsu  = load_err_i | store_err_i;

  // anything that needs a trip through flush
  assign special_req_o = exc_req_insn | dec_flags_i.mret | dec_flags_i.wfi |
                         dec_flags_i.csr_status | exc_req_lsu;

  // in flush the lsu pulse is gone, so use the captured copy
  assign exc_pending_o = exc_req_insn | load_err_q | store_err_q;

  // error pulses live for one cycle, keep them until flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      load_err_q  <= load_err_i;
      store_err_q <= store_err_i;
    end
  end

  //////////////////////////////
  // cause and trap value
  //////////////////////////////

  always_comb begin
    exc_cause_o = exc_cause_e'('0);
    mtval_o     = '0;

    // priority follows the privileged spec table
    if (dec_flags_i.illegal) begin
      exc_cause_o = exc_cause_illegal_insn;
      // report the bits as fetched
      mtval_o     = instr_is_compressed_i ? {16'b0, instr_compressed_i} : instr_i;
    end else if (dec_flags_i.ecall) begin
      exc_cause_o = exc_cause_ecall_mmode;
    end else if (dec_flags_i.ebreak) begin
      // no debug mode, ebreak always traps
      exc_cause_o = exc_cause_breakpoint;
    end else if (store_err_q) begin
      exc_cause_o = exc_cause_store_access_fault;
      mtval_o     = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc_cause_o = exc_cause_load_access_fault;
      mtval_o     = lsu_addr_last_i;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // one lsu transaction at a time, so both errors at once means a broken lsu
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_err_i |-> !store_err_i)
    else $error("load and store error raised together");

endmodule

/* hdl/ctrl_fsm.sv */
// decoder flags must stay valid through flush; interrupts wait while IF is halted by a stall
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          fetch_enable_i,
  input  logic                          instr_valid_i,
  input  ctrl_pkg::dec_flags_t          dec_flags_i,

  // from the exception encoder
  input  logic                          special_req_i,
  input  logic                          exc_pending_i,
  input  ctrl_pkg::exc_cause_e          exc_cause_i,
  input  logic [ctrl_pkg::xlen-1:0]     mtval_i,

  // jumps and branches resolved in ID
  input  logic                          branch_set_i,
  input  logic                          jump_set_i,

  // interrupts
  input  logic                          irq_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::irq_id_w-1:0] irq_id_i,
  input  logic                          m_ie_i,

  input  ctrl_pkg::stall_t              stall_i,

  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          instr_req_o,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t           csr_ctrl_o,
  output logic                          exc_ack_o,
  output logic                          irq_ack_o,
  output logic [ctrl_pkg::irq_id_w-1:0] irq_id_o,
  output logic                          id_in_ready_o,
  output logic                          instr_valid_clear_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic stall;
  logic halt_if;
  logic halt_id;
  logic handle_irq;

  // the instruction in ID needs more cycles
  assign stall = |stall_i;

  // no debug mode here, so only the global enable masks
  assign handle_irq = irq_req_i & m_ie_i;

  // id is only passed through, the ack tells the source which one was taken
  assign irq_id_o = irq_id_i;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    instr_req_o   = 1'b1;
    exc_ack_o     = 1'b0;
    irq_ack_o     = 1'b0;
    halt_if       = 1'b0;
    halt_id       = 1'b0;

    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_mux     = pc_boot;
    pc_ctrl_o.exc_pc_mux = exc_pc_irq;
    csr_ctrl_o           = '0;

    unique case (state_q)
      st_reset: begin
        // hold the boot address until fetch is enabled
        instr_req_o      = 1'b0;
        pc_ctrl_o.pc_set = 1'b1;
        if (fetch_enable_i) begin
          state_d = st_boot_set;
        end
      end

      st_boot_set: begin
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = st_first_fetch;
      end

      st_first_fetch: begin
        first_fetch_o = 1'b1;
        // halt_if is low here unless an irq is taken
        if (!stall) begin
          state_d = st_decode;
        end
        // pipeline was flushed before sleep, safe to trap now
        if (handle_irq) begin
          state_d = st_irq_taken;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      st_decode: begin
        if (instr_valid_i) begin
          if (branch_set_i || jump_set_i) begin
            // redirect in the same cycle, repeated while stalled
            pc_ctrl_o.pc_set = 1'b1;
            pc_ctrl_o.pc_mux = pc_jump;
          end else if (special_req_i) begin
            state_d = st_flush;
            halt_if = 1'b1;
            halt_id = 1'b1;
          end
        end
        // irq only between instructions
        if (!stall && !special_req_i && handle_irq) begin
          state_d = st_irq_taken;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      st_irq_taken: begin
        pc_ctrl_o.pc_set      = 1'b1;
        pc_ctrl_o.pc_mux      = pc_exc;
        pc_ctrl_o.exc_pc_mux  = exc_pc_irq;
        // mepc gets the pc in IF, the next unexecuted one
        csr_ctrl_o.save_if    = 1'b1;
        csr_ctrl_o.save_cause = 1'b1;
        csr_ctrl_o.cause      = exc_cause_e'({1'b1, irq_id_i});
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
        state_d               = st_decode;
      end

      st_flush: begin
        halt_if = 1'b1;
        halt_id = 1'b1;
        state_d = st_decode;
        if (exc_pending_i) begin
          // mepc gets the faulting pc in ID
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = pc_exc;
          pc_ctrl_o.exc_pc_mux  = exc_pc_exc;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = exc_cause_i;
          csr_ctrl_o.mtval      = mtval_i;
        end else if (dec_flags_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_mux        = pc_eret;
          csr_ctrl_o.restore_mret = 1'b1;
        end else if (dec_flags_i.wfi) begin
          state_d = st_wait_sleep;
        end
        // csr status writes only need the flush itself
      end

      st_wait_sleep: begin
        // one cycle for the pipeline to drain
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        state_d     = st_sleep;
      end

      st_sleep: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        // wake on any pending line, even if masked
        if (irq_i) begin
          state_d = st_first_fetch;
        end
      end
    endcase
  end

  //////////////////////////////
  // ID stage handshake
  //////////////////////////////

  // accept a new instruction
  assign id_in_ready_o       = ~stall & ~halt_if;
  // drop the instruction once done, or when it is killed
  assign instr_valid_clear_o = ~stall | halt_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_reset;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // the acked id is the requested one, so the source holds it until the ack
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> irq_id_i == $past(irq_id_i))
    else $error("irq id changed between request and ack");

  // a trap entry never writes an empty cause into mcause
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_ctrl_o.save_cause |-> csr_ctrl_o.cause != exc_cause_e'('0))
    else $error("trap entry without a cause");

endmodule

/* hdl/ctrl_pkg.sv */
// machine mode only; widths fixed by RV32 and the enum encodings must match the CSR file
package ctrl_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // data and instruction width
  localparam int unsigned xlen     = 32;
  // interrupt id carried in the low bits of mcause
  localparam int unsigned irq_id_w = 5;

  //////////////////////////////
  // enumerations
  //////////////////////////////

  // fetch address source of the prefetcher
  typedef enum logic [1:0] {
    pc_boot = 2'd0,
    pc_jump = 2'd1,
    pc_exc  = 2'd2,
    pc_eret = 2'd3
  } pc_sel_e;

  // vector picked on a trap
  typedef enum logic {
    exc_pc_irq = 1'b0,
    exc_pc_exc = 1'b1
  } exc_pc_sel_e;

  // mcause values, top bit set for interrupts with the id below it
  typedef enum logic [5:0] {
    exc_cause_illegal_insn       = 6'd2,
    exc_cause_breakpoint         = 6'd3,
    exc_cause_load_access_fault  = 6'd5,
    exc_cause_store_access_fault = 6'd7,
    exc_cause_ecall_mmode        = 6'd11
  } exc_cause_e;

  // controller states
  typedef enum logic [2:0] {
    st_reset, st_boot_set, st_first_fetch, st_decode,
    st_flush, st_irq_taken, st_wait_sleep, st_sleep
  } ctrl_state_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  // decoder flags of the instruction sitting in ID
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic csr_status;
  } dec_flags_t;

  // multicycle stall sources
  typedef struct packed {
    logic lsu;
    logic multdiv;
    logic jump;
    logic branch;
  } stall_t;

  // redirect command to the prefetcher
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  // update command to the CSR file
  typedef struct packed {
    logic            save_if;
    logic            save_id;
    logic            restore_mret;
    logic            save_cause;
    exc_cause_e      cause;
    logic [xlen-1:0] mtval;
  } csr_ctrl_t;

endpackage

/* hdl/ctrl_top.sv */
// machine mode only, no debug support; all outputs combinational from state and inputs
`timescale 1ns/1ps

module ctrl_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          fetch_enable_i,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,

  // IF/ID register
  input  ctrl_pkg::dec_flags_t          dec_flags_i,
  input  logic                          instr_valid_i,
  input  logic [ctrl_pkg::xlen-1:0]     instr_i,
  input  logic [15:0]                   instr_compressed_i,
  input  logic                          instr_is_compressed_i,
  output logic                          id_in_ready_o,
  output logic                          instr_valid_clear_o,

  // lsu
  input  logic [ctrl_pkg::xlen-1:0]     lsu_addr_last_i,
  input  logic                          load_err_i,
  input  logic                          store_err_i,

  // jumps and branches
  input  logic                          branch_set_i,
  input  logic                          jump_set_i,

  // interrupts
  input  logic                          irq_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::irq_id_w-1:0] irq_id_i,
  input  logic                          m_ie_i,

  input  ctrl_pkg::stall_t              stall_i,

  // prefetcher and csr file
  output logic                          instr_req_o,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t           csr_ctrl_o,
  output logic                          exc_ack_o,
  output logic                          irq_ack_o,
  output logic [ctrl_pkg::irq_id_w-1:0] irq_id_o
);
  import ctrl_pkg::*;

  logic            special_req;
  logic            exc_pending;
  exc_cause_e      exc_cause;
  logic [xlen-1:0] mtval;

  // cause and trap value, plus the captured lsu errors
  ctrl_exc_encode u_exc_encode (
    .clk_i,
    .rst_ni,
    .dec_flags_i,
    .instr_i,
    .instr_compressed_i,
    .instr_is_compressed_i,
    .lsu_addr_last_i,
    .load_err_i,
    .store_err_i,
    .special_req_o (special_req),
    .exc_pending_o (exc_pending),
    .exc_cause_o   (exc_cause),
    .mtval_o       (mtval)
  );

  // state machine and ID stall logic
  ctrl_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .fetch_enable_i,
    .instr_valid_i,
    .dec_flags_i,
    .special_req_i (special_req),
    .exc_pending_i (exc_pending),
    .exc_cause_i   (exc_cause),
    .mtval_i       (mtval),
    .branch_set_i,
    .jump_set_i,
    .irq_i,
    .irq_req_i,
    .irq_id_i,
    .m_ie_i,
    .stall_i,
    .ctrl_busy_o,
    .first_fetch_o,
    .instr_req_o,
    .pc_ctrl_o,
    .csr_ctrl_o,
    .exc_ack_o,
    .irq_ack_o,
    .irq_id_o,
    .id_in_ready_o,
    .instr_valid_clear_o
  );

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, exit status follows the result line
verilator --binary --timing --assert -f filelist.f --top-module tb_ctrl -o sim_ctrl \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_ctrl)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && exit 0 || exit 1

/* include/ctrl_tb_model.svh */
// include inside the testbench module; mismatches bump err_cnt, which the testbench reports
`ifndef CTRL_TB_MODEL_SVH
`define CTRL_TB_MODEL_SVH

// mismatch count over the whole run
int err_cnt = 0;

//////////////////////////////
// reference model
//////////////////////////////

// redirect as the prefetcher should see it
function automatic ctrl_pkg::pc_ctrl_t model_pc(input ctrl_pkg::pc_sel_e mux,
                                                input ctrl_pkg::exc_pc_sel_e exc);
  ctrl_pkg::pc_ctrl_t p;
  p.pc_set     = 1'b1;
  p.pc_mux     = mux;
  p.exc_pc_mux = exc;
  return p;
endfunction

// boot sequence as seen from the state register
function automatic ctrl_pkg::ctrl_state_e model_boot_next(input ctrl_pkg::ctrl_state_e st,
                                                         input logic fetch_en,
                                                         input logic ready);
  case (st)
    ctrl_pkg::st_reset:       return fetch_en ? ctrl_pkg::st_boot_set : ctrl_pkg::st_reset;
    ctrl_pkg::st_boot_set:    return ctrl_pkg::st_first_fetch;
    ctrl_pkg::st_first_fetch: return ready ? ctrl_pkg::st_decode : ctrl_pkg::st_first_fetch;
    default:                  return st;
  endcase
endfunction

// csr command in flush, priority illegal > ecall > ebreak > store > load
function automatic ctrl_pkg::csr_ctrl_t model_csr_exc(input ctrl_pkg::dec_flags_t f,
                                                      input logic ld_err,
                                                      input logic st_err,
                                                      input logic [31:0] instr,
                                                      input logic [15:0] instr_c,
                                                      input logic is_c,
                                                      input logic [31:0] addr);
  ctrl_pkg::csr_ctrl_t c;
  c            = '0;
  c.save_id    = 1'b1;
  c.save_cause = 1'b1;
  if (f.illegal) begin
    c.cause = ctrl_pkg::exc_cause_illegal_insn;
    c.mtval = is_c ? {16'b0, instr_c} : instr;
  end else if (f.ecall) begin
    c.cause = ctrl_pkg::exc_cause_ecall_mmode;
  end else if (f.ebreak) begin
    c.cause = ctrl_pkg::exc_cause_breakpoint;
  end else if (st_err) begin
    c.cause = ctrl_pkg::exc_cause_store_access_fault;
    c.mtval = addr;
  end else if (ld_err) begin
    c.cause = ctrl_pkg::exc_cause_load_access_fault;
    c.mtval = addr;
  end
  return c;
endfunction

// csr command in irq_taken
function automatic ctrl_pkg::csr_ctrl_t model_csr_irq(input logic [4:0] id);
  ctrl_pkg::csr_ctrl_t c;
  c            = '0;
  c.save_if    = 1'b1;
  c.save_cause = 1'b1;
  // interrupt flag is bit 5 of the cause, worth 32
  c.cause      = ctrl_pkg::exc_cause_e'(6'd32 + id);
  return c;
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_pc(input string name, input ctrl_pkg::pc_ctrl_t exp,
                        input ctrl_pkg::pc_ctrl_t act);
  if (act !== exp) begin
    $display("[ERROR] %s pc_ctrl expected %b actual %b", name, exp, act);
    err_cnt++;
  end
endtask

task automatic check_csr(input string name, input ctrl_pkg::csr_ctrl_t exp,
                         input ctrl_pkg::csr_ctrl_t act);
  if (act !== exp) begin
    $display("[ERROR] %s csr_ctrl expected %h actual %h", name, exp, act);
    err_cnt++;
  end
endtask

task automatic check_id(input string name, input logic [ctrl_pkg::irq_id_w-1:0] exp,
                        input logic [ctrl_pkg::irq_id_w-1:0] act);
  if (act !== exp) begin
    $display("[ERROR] %s irq_id expected %0d actual %0d", name, exp, act);
    err_cnt++;
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] %s expected %b actual %b", name, exp, act);
    err_cnt++;
  end
endtask

`endif

/* tb/tb_ctrl.sv */
// random run seeded with 35; no debug mode, and the stimulus keeps one trap in flight at a time
`timescale 1ns/1ps

module tb_ctrl;
  import ctrl_pkg::*;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                fetch_enable_i;
  logic                ctrl_busy_o;
  logic                first_fetch_o;
  dec_flags_t          dec_flags_i;
  logic                instr_valid_i;
  logic [xlen-1:0]     instr_i;
  logic [15:0]         instr_compressed_i;
  logic                instr_is_compressed_i;
  logic                id_in_ready_o;
  logic                instr_valid_clear_o;
  logic [xlen-1:0]     lsu_addr_last_i;
  logic                load_err_i;
  logic                store_err_i;
  logic                branch_set_i;
  logic                jump_set_i;
  logic                irq_i;
  logic                irq_req_i;
  logic [irq_id_w-1:0] irq_id_i;
  logic                m_ie_i;
  stall_t              stall_i;
  logic                instr_req_o;
  pc_ctrl_t            pc_ctrl_o;
  csr_ctrl_t           csr_ctrl_o;
  logic                exc_ack_o;
  logic                irq_ack_o;
  logic [irq_id_w-1:0] irq_id_o;

  ctrl_state_e boot_st;
  logic [31:0] rnd;
  dec_flags_t  flags;
  stall_t      stl;
  csr_ctrl_t   csr_exp;

  `include "ctrl_tb_model.svh"

  always #5 clk_i = ~clk_i;

  ctrl_top uut (.*);

  //////////////////////////////
  // helpers
  //////////////////////////////

  // idle IF/ID, lsu and irq lines
  task automatic clear_inputs();
    dec_flags_i           = '0;
    instr_valid_i         = 1'b0;
    instr_i               = '0;
    instr_compressed_i    = '0;
    instr_is_compressed_i = 1'b0;
    lsu_addr_last_i       = '0;
    load_err_i            = 1'b0;
    store_err_i           = 1'b0;
    branch_set_i          = 1'b0;
    jump_set_i            = 1'b0;
    irq_i                 = 1'b0;
    irq_req_i             = 1'b0;
    irq_id_i              = '0;
    m_ie_i                = 1'b0;
    stall_i               = '0;
  endtask

  // poll busy once per cycle, give up after limit cycles
  task automatic wait_busy(input logic level, input int limit, input string what);
    int cnt;
    cnt = 0;
    while (ctrl_busy_o !== level && cnt < limit) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (ctrl_busy_o !== level) begin
      $display("timeout: ctrl_busy_o did not go to %b while %s", level, what);
      err_cnt++;
    end
  endtask

  initial begin
    void'($urandom(35));
    clear_inputs();
    fetch_enable_i = 1'b0;
    rst_ni         = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    //////////////////////////////
    // boot
    //////////////////////////////

    // no fetch before the enable, boot pc held
    repeat (3) begin
      @(negedge clk_i);
      #1;
      check_bit("boot_idle", 1'b0, instr_req_o);
      check_pc("boot_idle", model_pc(pc_boot, exc_pc_irq), pc_ctrl_o);
    end
    @(negedge clk_i);
    fetch_enable_i = 1'b1;
    #1;
    boot_st = st_reset;
    // walks boot_set, first_fetch, decode
    repeat (3) begin
      boot_st = model_boot_next(boot_st, fetch_enable_i, stall_i == '0);
      @(negedge clk_i);
      #1;
      check_bit("boot_req", boot_st != st_reset, instr_req_o);
      check_bit("boot_first_fetch", boot_st == st_first_fetch, first_fetch_o);
      if (boot_st == st_boot_set) begin
        check_pc("boot_set", model_pc(pc_boot, exc_pc_irq), pc_ctrl_o);
      end
    end
    instr_valid_i = 1'b1;

    //////////////////////////////
    // exception priority
    //////////////////////////////

    repeat (24) begin
      rnd           = $urandom;
      flags         = '0;
      flags.illegal = rnd[0];
      flags.ecall   = rnd[1];
      // never an empty combination
      flags.ebreak  = rnd[2] | ~(rnd[0] | rnd[1]);
      @(negedge clk_i);
      dec_flags_i           = flags;
      instr_i               = $urandom;
      instr_compressed_i    = rnd[31:16];
      instr_is_compressed_i = rnd[3];
      // flags stay up through flush
      @(negedge clk_i);
      #1;
      csr_exp = model_csr_exc(flags, 1'b0, 1'b0, instr_i, instr_compressed_i,
                              instr_is_compressed_i, lsu_addr_last_i);
      check_pc("exc_prio", model_pc(pc_exc, exc_pc_exc), pc_ctrl_o);
      check_csr("exc_prio", csr_exp, csr_ctrl_o);
      @(negedge clk_i);
      dec_flags_i = '0;
    end

    //////////////////////////////
    // access faults
    //////////////////////////////

    repeat (16) begin
      rnd = $urandom;
      @(negedge clk_i);
      lsu_addr_last_i = $urandom;
      load_err_i      = rnd[0];
      store_err_i     = ~rnd[0];
      @(negedge clk_i);
      csr_exp = model_csr_exc('0, load_err_i, store_err_i, instr_i, instr_compressed_i,
                              instr_is_compressed_i, lsu_addr_last_i);
      // pulse is one cycle wide
      load_err_i  = 1'b0;
      store_err_i = 1'b0;
      #1;
      check_pc("access_fault", model_pc(pc_exc, exc_pc_exc), pc_ctrl_o);
      check_csr("access_fault", csr_exp, csr_ctrl_o);
    end

    //////////////////////////////
    // interrupts
    //////////////////////////////

    repeat (16) begin
      rnd = $urandom;
      @(negedge clk_i);
      irq_req_i = 1'b1;
      irq_id_i  = rnd[4:0];
      m_ie_i    = 1'b1;
      #1;
      check_bit("irq_wait", 1'b0, irq_ack_o);
      // id stays valid in irq_taken
      @(negedge clk_i);
      irq_req_i = 1'b0;
      #1;
      check_bit("irq_ack", 1'b1, irq_ack_o);
      check_bit("irq_exc_ack", 1'b1, exc_ack_o);
      check_id("irq_id", rnd[4:0], irq_id_o);
      check_pc("irq_pc", model_pc(pc_exc, exc_pc_irq), pc_ctrl_o);
      check_csr("irq_cause", model_csr_irq(rnd[4:0]), csr_ctrl_o);
    end

    // masked by m_ie
    rnd = $urandom;
    @(negedge clk_i);
    irq_req_i = 1'b1;
    irq_id_i  = rnd[4:0];
    m_ie_i    = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      #1;
      check_bit("irq_masked", 1'b0, irq_ack_o);
    end
    // enabled but held off by a stall
    m_ie_i  = 1'b1;
    stall_i = stall_t'(4'b0001 << rnd[9:8]);
    repeat (4) begin
      @(negedge clk_i);
      #1;
      check_bit("irq_stalled", 1'b0, irq_ack_o);
      check_bit("irq_stall_ready", 1'b0, id_in_ready_o);
    end
    @(negedge clk_i);
    irq_req_i = 1'b0;
    stall_i   = '0;

    //////////////////////////////
    // mret, branches and stalls
    //////////////////////////////

    repeat (4) begin
      @(negedge clk_i);
      dec_flags_i.mret = 1'b1;
      @(negedge clk_i);
      #1;
      csr_exp              = '0;
      csr_exp.restore_mret = 1'b1;
      check_pc("mret", model_pc(pc_eret, exc_pc_irq), pc_ctrl_o);
      check_csr("mret", csr_exp, csr_ctrl_o);
      @(negedge clk_i);
      dec_flags_i = '0;
    end

    repeat (24) begin
      rnd = $urandom;
      @(negedge clk_i);
      branch_set_i = rnd[0];
      jump_set_i   = rnd[1];
      // stalled about half the time
      stl          = stall_t'(rnd[7:4] & {4{rnd[2]}});
      stall_i      = stl;
      #1;
      if (rnd[0] | rnd[1]) begin
        check_pc("branch", model_pc(pc_jump, exc_pc_irq), pc_ctrl_o);
      end else begin
        check_pc("branch", '0, pc_ctrl_o);
      end
      check_bit("stall_ready", stl == '0, id_in_ready_o);
      check_bit("stall_clear", stl == '0, instr_valid_clear_o);
    end
    @(negedge clk_i);
    branch_set_i = 1'b0;
    jump_set_i   = 1'b0;
    stall_i      = '0;

    //////////////////////////////
    // wfi and wake-up
    //////////////////////////////

    @(negedge clk_i);
    dec_flags_i.wfi = 1'b1;
    @(negedge clk_i);
    #1;
    check_bit("wfi_flush_busy", 1'b1, ctrl_busy_o);
    @(negedge clk_i);
    dec_flags_i = '0;
    #1;
    wait_busy(1'b0, 4, "entering sleep");
    repeat (6) begin
      @(negedge clk_i);
      #1;
      check_bit("sleep_busy", 1'b0, ctrl_busy_o);
      check_bit("sleep_req", 1'b0, instr_req_o);
    end
    @(negedge clk_i);
    irq_i = 1'b1;
    #1;
    wait_busy(1'b1, 8, "waking from sleep");
    @(negedge clk_i);
    irq_i = 1'b0;

    @(negedge clk_i);
    $display("checks done, errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
